// File: logic/lsq_pkg.sv
// Load/store queue package with shared widths, id type and address word layout
`default_nettype none

package lsq_pkg;

    ////////////////////////////////////////////////////////////
    // Instruction ids

    // Id width, shared by both queues
    localparam int ID_W = 4;

    typedef logic [ID_W-1:0] id_t;

    ////////////////////////////////////////////////////////////
    // Address hashing

    // Short hash used for load vs store alias checks
    localparam int HASH_W = 8;

    typedef logic [HASH_W-1:0] addr_hash_t;

    // Word index and byte offset view of an address
    typedef struct packed {
        logic [29:0] word_index;
        logic [1:0]  byte_offset;
    } lsq_addr_fields_t;

    // Same 32 bits, either raw or split into fields
    typedef union packed {
        logic [31:0]      word;
        lsq_addr_fields_t fields;
    } lsq_addr_t;

    ////////////////////////////////////////////////////////////
    // Access encoding

    // RISC-V funct3, access width and sign
    typedef logic [2:0] fn3_t;

endpackage

`default_nettype wire

// File: logic/lsq_addr_hash.sv
// Intake stage that folds a request address into a short registered hash
`default_nettype none

module lsq_addr_hash
    import lsq_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       flush,
    input  logic       take,
    input  lsq_addr_t  addr,
    output addr_hash_t addr_hash
);

    // Folded hash of the current request
    addr_hash_t folded;

    ////////////////////////////////////////////////////////////
    // XOR fold of the word index

    // Byte offset left out, same word always hashes alike
    always_comb begin
        folded = '0;
        for (int i = 0; i < 30; i++) begin
            folded[i % HASH_W] ^= addr.fields.word_index[i];
        end
    end

    ////////////////////////////////////////////////////////////
    // Hash register

    // Updated only on an accepted request
    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            addr_hash <= '0;
        end else if (take) begin
            addr_hash <= folded;
        end
    end

endmodule

`default_nettype wire

// File: logic/lsq_store_queue.sv
// Circular store queue holding stores until retire, with hash checks for loads
`default_nettype none

module lsq_store_queue
    import lsq_pkg::*;
#(
    parameter int SQ_DEPTH = 4,
    localparam int PTR_W = $clog2(SQ_DEPTH)
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                flush,

    // New store from issue
    input  logic                push,
    input  lsq_addr_t           addr,
    input  logic [3:0]          be,
    input  fn3_t                fn3,
    input  logic [31:0]         data_in,
    input  id_t                 id,

    // Alias check for the delayed load
    input  addr_hash_t          addr_hash,
    input  logic                load_check,
    output logic [SQ_DEPTH-1:0] match_mask,
    input  logic [SQ_DEPTH-1:0] prev_conflicts,
    output logic                store_conflict,

    // Retire port
    input  logic                retire_valid,
    input  id_t                 retire_id,

    // Head toward the output stage
    input  logic                store_ack,
    output logic                full,
    output logic                empty,
    output logic                head_valid,
    output logic [PTR_W-1:0]    head_slot,
    output lsq_addr_t           head_addr,
    output logic [3:0]          head_be,
    output fn3_t                head_fn3,
    output logic [31:0]         head_data
);

    // Pointers carry one extra wrap bit
    logic [PTR_W:0]      wr_ptr;
    logic [PTR_W:0]      rd_ptr;
    logic [PTR_W-1:0]    wr_slot;

    // Per-entry state
    logic [SQ_DEPTH-1:0] valid;
    logic [SQ_DEPTH-1:0] retired;
    addr_hash_t          hashes [SQ_DEPTH];

    // Per-entry payload
    lsq_addr_t           addrs [SQ_DEPTH];
    logic [3:0]          bes [SQ_DEPTH];
    fn3_t                fn3s [SQ_DEPTH];
    logic [31:0]         datas [SQ_DEPTH];
    id_t                 ids [SQ_DEPTH];

    // Hash arrives one cycle after the store
    logic                hash_pending;
    logic [PTR_W-1:0]    hash_slot;

    assign wr_slot   = wr_ptr[PTR_W-1:0];
    assign head_slot = rd_ptr[PTR_W-1:0];

    ////////////////////////////////////////////////////////////
    // Occupancy

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) && (wr_slot == head_slot);

    ////////////////////////////////////////////////////////////
    // Control state

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            valid        <= '0;
            retired      <= '0;
            hash_pending <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (store_ack) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            hash_pending <= push;

            for (int i = 0; i < SQ_DEPTH; i++) begin
                if (push && (wr_slot == PTR_W'(i))) begin
                    // Fresh entry, not yet retired
                    valid[i]   <= 1'b1;
                    retired[i] <= 1'b0;
                end else begin
                    if (store_ack && (head_slot == PTR_W'(i))) begin
                        valid[i] <= 1'b0;
                    end
                    // Retire pulse releases the store with that id
                    if (retire_valid && valid[i] && (ids[i] == retire_id)) begin
                        retired[i] <= 1'b1;
                    end
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Payload and hash storage

    always_ff @(posedge clk) begin
        if (push) begin
            addrs[wr_slot] <= addr;
            bes[wr_slot]   <= be;
            fn3s[wr_slot]  <= fn3;
            datas[wr_slot] <= data_in;
            ids[wr_slot]   <= id;
        end
        hash_slot <= wr_slot;
        // Hash register now holds this store's hash
        if (hash_pending) begin
            hashes[hash_slot] <= addr_hash;
        end
    end

    ////////////////////////////////////////////////////////////
    // Load alias check

    always_comb begin
        for (int i = 0; i < SQ_DEPTH; i++) begin
            match_mask[i] = load_check && valid[i] && (hashes[i] == addr_hash);
        end
    end

    // Head load waits while any of its older stores remain
    assign store_conflict = |(prev_conflicts & valid);

    ////////////////////////////////////////////////////////////
    // Head outputs

    assign head_valid = valid[head_slot] & retired[head_slot];
    assign head_addr  = addrs[head_slot];
    assign head_be    = bes[head_slot];
    assign head_fn3   = fn3s[head_slot];
    assign head_data  = datas[head_slot];

endmodule

`default_nettype wire

// File: logic/lsq_load_queue.sv
// Load FIFO with a delay stage, each load tagged with its older-store conflict mask
`default_nettype none

module lsq_load_queue
    import lsq_pkg::*;
#(
    parameter int LQ_DEPTH = 4,
    parameter int SQ_DEPTH = 4,
    localparam int PTR_W = $clog2(LQ_DEPTH)
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                flush,
    input  logic                push,
    input  lsq_addr_t           addr,
    input  fn3_t                fn3,
    input  id_t                 id,
    input  logic [SQ_DEPTH-1:0] match_mask,
    input  logic                load_ack,
    input  logic [SQ_DEPTH-1:0] clear_mask,
    output logic                full,
    output logic                empty,
    output logic                head_valid,
    output lsq_addr_t           head_addr,
    output fn3_t                head_fn3,
    output id_t                 head_id,
    output logic [SQ_DEPTH-1:0] head_conflicts
);

    // Delay stage, waits for the hash compare
    logic                pend_valid;
    lsq_addr_t           pend_addr;
    fn3_t                pend_fn3;
    id_t                 pend_id;

    logic [PTR_W:0]      wr_ptr;
    logic [PTR_W:0]      rd_ptr;
    logic [PTR_W:0]      occupancy;
    logic [PTR_W+1:0]    total;

    lsq_addr_t           addrs [LQ_DEPTH];
    fn3_t                fn3s [LQ_DEPTH];
    id_t                 ids [LQ_DEPTH];
    logic [SQ_DEPTH-1:0] masks [LQ_DEPTH];

    ////////////////////////////////////////////////////////////
    // Occupancy, delay stage included

    assign occupancy = wr_ptr - rd_ptr;
    assign total     = (PTR_W + 2)'(occupancy) + (PTR_W + 2)'(pend_valid);
    assign full      = (total >= (PTR_W + 2)'(LQ_DEPTH));
    assign empty     = (total == '0);

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            pend_valid <= 1'b0;
            wr_ptr     <= '0;
            rd_ptr     <= '0;
        end else begin
            pend_valid <= push;
            if (pend_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (load_ack) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Payload and conflict masks

    always_ff @(posedge clk) begin
        if (push) begin
            pend_addr <= addr;
            pend_fn3  <= fn3;
            pend_id   <= id;
        end
        for (int i = 0; i < LQ_DEPTH; i++) begin
            // Freed store slots drop out of every mask
            if (pend_valid && (wr_ptr[PTR_W-1:0] == PTR_W'(i))) begin
                addrs[i] <= pend_addr;
                fn3s[i]  <= pend_fn3;
                ids[i]   <= pend_id;
                masks[i] <= match_mask & ~clear_mask;
            end else begin
                masks[i] <= masks[i] & ~clear_mask;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Head outputs

    assign head_valid     = (occupancy != '0);
    assign head_addr      = addrs[rd_ptr[PTR_W-1:0]];
    assign head_fn3       = fn3s[rd_ptr[PTR_W-1:0]];
    assign head_id        = ids[rd_ptr[PTR_W-1:0]];
    assign head_conflicts = masks[rd_ptr[PTR_W-1:0]];

endmodule

`default_nettype wire

// File: logic/lsq_output_select.sv
// Output stage picking a load or store for the memory port and raising acks
`default_nettype none

module lsq_output_select
    import lsq_pkg::*;
#(
    parameter int SQ_DEPTH = 4,
    localparam int PTR_W = $clog2(SQ_DEPTH)
) (
    input  logic                load_valid,
    input  logic                store_conflict,
    input  logic                store_valid,
    input  logic                accepted,

    // Load queue head
    input  lsq_addr_t           lq_addr,
    input  fn3_t                lq_fn3,
    input  id_t                 lq_id,

    // Store queue head
    input  lsq_addr_t           sq_addr,
    input  logic [3:0]          sq_be,
    input  fn3_t                sq_fn3,
    input  logic [31:0]         sq_data,
    input  logic [PTR_W-1:0]    sq_head_slot,

    output logic                transaction_ready,
    output logic                txn_load,
    output lsq_addr_t           txn_addr,
    output logic [3:0]          txn_be,
    output fn3_t                txn_fn3,
    output logic [31:0]         txn_data,
    output id_t                 txn_id,
    output logic                load_ack,
    output logic                store_ack,
    output logic [SQ_DEPTH-1:0] clear_mask
);

    logic load_selected;

    ////////////////////////////////////////////////////////////
    // Selection

    // Loads win unless an older aliasing store is still queued
    assign load_selected     = load_valid & ~store_conflict;
    assign transaction_ready = load_selected | store_valid;

    assign load_ack  = accepted & load_selected;
    assign store_ack = accepted & ~load_selected & store_valid;

    ////////////////////////////////////////////////////////////
    // Transaction fields

    assign txn_load = load_selected;
    assign txn_addr = load_selected ? lq_addr : sq_addr;
    // No byte enables on a load
    assign txn_be   = load_selected ? 4'b0000 : sq_be;
    assign txn_fn3  = load_selected ? lq_fn3 : sq_fn3;
    assign txn_data = sq_data;
    assign txn_id   = lq_id;

    // One-hot slot freed by the store ack
    always_comb begin
        clear_mask = '0;
        if (store_ack) begin
            clear_mask[sq_head_slot] = 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: logic/load_store_queue.sv
// Load/store queue top level linking intake hash, both queues and output select
`default_nettype none

module load_store_queue
    import lsq_pkg::*;
#(
    parameter int LQ_DEPTH = 4,
    parameter int SQ_DEPTH = 4
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        flush,

    // Issue side
    input  logic        request_valid,
    input  logic        load,
    input  logic        store,
    input  lsq_addr_t   addr,
    input  logic [3:0]  be,
    input  fn3_t        fn3,
    input  logic [31:0] data_in,
    input  id_t         id,
    output logic        ready,

    // Retire side
    input  logic        retire_valid,
    input  id_t         retire_id,

    // Memory side
    output logic        transaction_ready,
    input  logic        accepted,
    output logic        txn_load,
    output lsq_addr_t   txn_addr,
    output logic [3:0]  txn_be,
    output fn3_t        txn_fn3,
    output logic [31:0] txn_data,
    output id_t         txn_id,
    output logic        empty
);

    localparam int SQ_PTR_W = $clog2(SQ_DEPTH);

    logic                take;
    logic                load_check;
    addr_hash_t          addr_hash;

    // Store queue side
    logic                sq_full;
    logic                sq_empty;
    logic                sq_valid;
    logic                store_conflict;
    logic [SQ_DEPTH-1:0] match_mask;
    logic [SQ_PTR_W-1:0] sq_slot;
    lsq_addr_t           sq_addr;
    logic [3:0]          sq_be;
    fn3_t                sq_fn3;
    logic [31:0]         sq_data;

    // Load queue side
    logic                lq_full;
    logic                lq_empty;
    logic                lq_valid;
    lsq_addr_t           lq_addr;
    fn3_t                lq_fn3;
    id_t                 lq_id;
    logic [SQ_DEPTH-1:0] lq_conflicts;

    logic                load_ack;
    logic                store_ack;
    logic [SQ_DEPTH-1:0] clear_mask;

    ////////////////////////////////////////////////////////////
    // Request handshake

    // Only the queue a request needs can hold it back
    assign ready = (~load | ~lq_full) & (~store | ~sq_full);
    assign take  = request_valid & ready;

    // Load compare happens the cycle after acceptance
    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            load_check <= 1'b0;
        end else begin
            load_check <= take & load;
        end
    end

    assign empty = lq_empty & sq_empty;

    ////////////////////////////////////////////////////////////
    // Stages

    lsq_addr_hash hash_inst (
        .clk(clk), .rst_n(rst_n), .flush(flush), .take(take),
        .addr(addr), .addr_hash(addr_hash)
    );

    lsq_store_queue #(.SQ_DEPTH(SQ_DEPTH)) sq_inst (
        .clk(clk), .rst_n(rst_n), .flush(flush),
        .push(take & store), .addr(addr), .be(be), .fn3(fn3), .data_in(data_in), .id(id),
        .addr_hash(addr_hash), .load_check(load_check), .match_mask(match_mask),
        .prev_conflicts(lq_conflicts), .store_conflict(store_conflict),
        .retire_valid(retire_valid), .retire_id(retire_id), .store_ack(store_ack),
        .full(sq_full), .empty(sq_empty), .head_valid(sq_valid), .head_slot(sq_slot),
        .head_addr(sq_addr), .head_be(sq_be), .head_fn3(sq_fn3), .head_data(sq_data)
    );

    lsq_load_queue #(.LQ_DEPTH(LQ_DEPTH), .SQ_DEPTH(SQ_DEPTH)) lq_inst (
        .clk(clk), .rst_n(rst_n), .flush(flush),
        .push(take & load), .addr(addr), .fn3(fn3), .id(id),
        .match_mask(match_mask), .load_ack(load_ack), .clear_mask(clear_mask),
        .full(lq_full), .empty(lq_empty), .head_valid(lq_valid), .head_addr(lq_addr),
        .head_fn3(lq_fn3), .head_id(lq_id), .head_conflicts(lq_conflicts)
    );

    lsq_output_select #(.SQ_DEPTH(SQ_DEPTH)) out_inst (
        .load_valid(lq_valid), .store_conflict(store_conflict), .store_valid(sq_valid),
        .accepted(accepted), .lq_addr(lq_addr), .lq_fn3(lq_fn3), .lq_id(lq_id),
        .sq_addr(sq_addr), .sq_be(sq_be), .sq_fn3(sq_fn3), .sq_data(sq_data),
        .sq_head_slot(sq_slot), .transaction_ready(transaction_ready),
        .txn_load(txn_load), .txn_addr(txn_addr), .txn_be(txn_be), .txn_fn3(txn_fn3),
        .txn_data(txn_data), .txn_id(txn_id), .load_ack(load_ack),
        .store_ack(store_ack), .clear_mask(clear_mask)
    );

endmodule

`default_nettype wire

// File: testbench/lsq_tb.sv
// Testbench for the load/store queue with LFSR traffic and a model of the release rules
`default_nettype none

module lsq_tb
    import lsq_pkg::*;
();

    localparam int LQ_DEPTH    = 4;
    localparam int SQ_DEPTH    = 4;
    localparam int NUM_MIXED   = 60;
    localparam int STALL_REQ   = 8;
    localparam int NUM_FLUSH   = 24;
    localparam int NUM_REQ     = NUM_MIXED + 2 * STALL_REQ + 2 * NUM_FLUSH;
    localparam int CYCLE_LIMIT = 40 * NUM_REQ + 2000;

    // One issued request as the model sees it
    typedef struct packed {
        logic        is_load;
        logic        retired;
        lsq_addr_t   addr;
        logic [3:0]  be;
        fn3_t        fn3;
        logic [31:0] data;
        id_t         id;
    } req_t;

    logic        clk;
    logic        rst_n;
    logic        flush;
    logic        request_valid;
    logic        load;
    logic        store;
    lsq_addr_t   addr;
    logic [3:0]  be;
    fn3_t        fn3;
    logic [31:0] data_in;
    id_t         id;
    logic        ready;
    logic        retire_valid;
    id_t         retire_id;
    logic        transaction_ready;
    logic        accepted;
    logic        txn_load;
    lsq_addr_t   txn_addr;
    logic [3:0]  txn_be;
    fn3_t        txn_fn3;
    logic [31:0] txn_data;
    id_t         txn_id;
    logic        empty;

    // Program-order list of requests still in flight
    req_t        model_q[$];
    // Pending retire pulses, oldest first
    id_t         retire_ids[$];
    int          retire_due[$];

    int          cycle = 0;
    logic [31:0] lfsr_state;
    int          issue_left;
    int          req_kind;
    int          req_delay;
    id_t         next_id;
    logic        took;
    logic        hold_accept;

    load_store_queue #(.LQ_DEPTH(LQ_DEPTH), .SQ_DEPTH(SQ_DEPTH)) load_store_queue_inst (
        .clk(clk), .rst_n(rst_n), .flush(flush),
        .request_valid(request_valid), .load(load), .store(store), .addr(addr),
        .be(be), .fn3(fn3), .data_in(data_in), .id(id), .ready(ready),
        .retire_valid(retire_valid), .retire_id(retire_id),
        .transaction_ready(transaction_ready), .accepted(accepted),
        .txn_load(txn_load), .txn_addr(txn_addr), .txn_be(txn_be), .txn_fn3(txn_fn3),
        .txn_data(txn_data), .txn_id(txn_id), .empty(empty)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Failure reporting and compare tasks

    task automatic end_with_failure(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_addr(input string name, input lsq_addr_t got, input lsq_addr_t exp);
        if (got !== exp) begin
            end_with_failure($sformatf("** Error %s: got %h, expected %h",
                                       name, got.word, exp.word));
        end
    endtask

    task automatic verify_id(input string name, input id_t got, input id_t exp);
        if (got !== exp) begin
            end_with_failure($sformatf("** Error %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic compare_fn3(input string name, input fn3_t got, input fn3_t exp);
        if (got !== exp) begin
            end_with_failure($sformatf("** Error %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic test_word(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            end_with_failure($sformatf("** Error %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic expect_be(input string name, input logic [3:0] got, input logic [3:0] exp);
        if (got !== exp) begin
            end_with_failure($sformatf("** Error %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic flag_equals(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            end_with_failure($sformatf("** Error %s: got %h, expected %h", name, got, exp));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Random source and reference model

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    // Address bits 31..2 folded into HASH_W bits
    function automatic addr_hash_t fold_hash(input lsq_addr_t a);
        addr_hash_t h;
        h = '0;
        for (int b = 2; b < 32; b++) begin
            h[(b - 2) % HASH_W] = h[(b - 2) % HASH_W] ^ a.word[b];
        end
        return h;
    endfunction

    function automatic int count_kind(input logic want_load);
        int   n;
        req_t r;
        n = 0;
        for (int i = 0; i < model_q.size(); i++) begin
            r = model_q[i];
            if (r.is_load == want_load) begin
                n++;
            end
        end
        return n;
    endfunction

    // Back-pressure only from the queue this request needs
    function automatic logic expected_ready();
        return !(load && count_kind(1'b1) >= LQ_DEPTH) &&
               !(store && count_kind(1'b0) >= SQ_DEPTH);
    endfunction

    // Legal candidate of one kind for the next transaction, -1 if none
    function automatic int legal_candidate(input logic want_load);
        req_t r;
        req_t older;
        for (int i = 0; i < model_q.size(); i++) begin
            r = model_q[i];
            if (!want_load && !r.is_load) begin
                // Oldest store only, and only once retired
                return r.retired ? i : -1;
            end
            if (want_load && r.is_load) begin
                // Oldest load, blocked by any older store of equal hash
                for (int j = 0; j < i; j++) begin
                    older = model_q[j];
                    if (!older.is_load && (fold_hash(older.addr) == fold_hash(r.addr))) begin
                        return -1;
                    end
                end
                return i;
            end
        end
        return -1;
    endfunction

    ////////////////////////////////////////////////////////////
    // Monitor at the falling edge

    task automatic judge_transaction();
        int   idx;
        req_t r;
        idx = legal_candidate(txn_load);
        if (idx < 0) begin
            end_with_failure(txn_load ? "A load reached the memory port while none was legal"
                                      : "A store reached the memory port before it was legal");
        end else begin
            r = model_q[idx];
            check_addr("txn_addr", txn_addr, r.addr);
            compare_fn3("txn_fn3", txn_fn3, r.fn3);
            expect_be("txn_be", txn_be, r.be);
            if (r.is_load) begin
                verify_id("txn_id", txn_id, r.id);
            end else begin
                test_word("txn_data", txn_data, r.data);
            end
            model_q.delete(idx);
        end
    endtask

    task automatic mark_retired(input id_t rid);
        req_t r;
        for (int i = 0; i < model_q.size(); i++) begin
            r = model_q[i];
            if (!r.is_load && (r.id == rid)) begin
                r.retired = 1'b1;
                model_q[i] = r;
            end
        end
    endtask

    task automatic record_request();
        req_t r;
        r.is_load = load;
        r.retired = 1'b0;
        r.addr    = addr;
        r.be      = load ? 4'b0000 : be;
        r.fn3     = fn3;
        r.data    = data_in;
        r.id      = id;
        model_q.push_back(r);
        // Stores get their retire pulse some cycles later
        if (!load) begin
            retire_ids.push_back(id);
            retire_due.push_back(cycle + req_delay);
        end
        took = 1'b1;
    endtask

    // Checks use the state before the coming edge, updates follow
    always @(negedge clk) begin
        if (rst_n) begin
            flag_equals("ready", ready, expected_ready());
            flag_equals("empty", empty, model_q.size() == 0);
            if (transaction_ready && accepted) begin
                judge_transaction();
            end
            if (retire_valid) begin
                mark_retired(retire_id);
            end
            if (request_valid && ready) begin
                record_request();
            end
            if (flush) begin
                model_q.delete();
                retire_ids.delete();
                retire_due.delete();
            end
        end
    end

    // Run limit
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle > CYCLE_LIMIT) begin
            end_with_failure($sformatf("Timeout: run did not finish within %0d cycles",
                                       CYCLE_LIMIT));
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus

    // Kind 0 mixed, 1 stores only, 2 loads only
    task automatic new_request();
        logic       is_load;
        logic       sign;
        logic [1:0] size;
        logic [1:0] off;
        case (req_kind)
            1:       is_load = 1'b0;
            2:       is_load = 1'b1;
            default: is_load = (rand_bits(1) != 0);
        endcase
        size = 2'(rand_bits(2) % 3);
        // Eight-word pool so aliasing is common
        addr.word = 32'h0000_4000 + (rand_bits(3) << 4);
        case (size)
            2'd0:    off = 2'(rand_bits(2));
            2'd1:    off = {rand_bits(1) != 0, 1'b0};
            default: off = 2'b00;
        endcase
        addr.fields.byte_offset = off;
        case (size)
            2'd0:    be = 4'b0001 << off;
            2'd1:    be = 4'b0011 << off;
            default: be = 4'b1111;
        endcase
        sign    = (size != 2'd2) && (rand_bits(1) != 0);
        load    = is_load;
        store   = !is_load;
        fn3     = is_load ? {sign, size} : {1'b0, size};
        be      = is_load ? 4'b0000 : be;
        data_in = is_load ? 32'h0 : rand_bits(32);
        id      = next_id;
        next_id = next_id + 1'b1;
        req_delay     = 1 + int'(rand_bits(3));
        request_valid = 1'b1;
        issue_left--;
    endtask

    // One clock of issue, accept and retire driving
    task automatic step_cycle();
        @(posedge clk);
        #2;
        if (took) begin
            request_valid = 1'b0;
            took          = 1'b0;
        end
        if (!request_valid && (issue_left > 0) && (rand_bits(2) != 0)) begin
            new_request();
        end
        accepted = hold_accept ? 1'b0 : (rand_bits(2) != 0);
        if ((retire_due.size() > 0) && (retire_due[0] <= cycle)) begin
            retire_valid = 1'b1;
            retire_id    = retire_ids.pop_front();
            void'(retire_due.pop_front());
        end else begin
            retire_valid = 1'b0;
        end
    endtask

    task automatic issue_and_run(input int kind, input int count);
        req_kind   = kind;
        issue_left = count;
        while ((issue_left > 0) || request_valid) begin
            step_cycle();
        end
    endtask

    task automatic drain();
        issue_left  = 0;
        hold_accept = 1'b0;
        while ((model_q.size() != 0) || request_valid) begin
            step_cycle();
        end
    endtask

    // Memory stalled until one queue is full and a request waits
    task automatic fill_until_stalled(input int kind);
        int depth;
        depth       = (kind == 2) ? LQ_DEPTH : SQ_DEPTH;
        hold_accept = 1'b1;
        req_kind    = kind;
        issue_left  = STALL_REQ;
        while ((count_kind(kind == 2) < depth) || !request_valid) begin
            step_cycle();
        end
        @(negedge clk);
        if (ready) begin
            end_with_failure("ready stayed high with a full queue and accepted held low");
        end
        hold_accept = 1'b0;
        while ((issue_left > 0) || request_valid) begin
            step_cycle();
        end
        drain();
    endtask

    // Single flush cycle with the issue and memory sides idle
    task automatic flush_queues();
        @(posedge clk);
        #2;
        request_valid = 1'b0;
        took          = 1'b0;
        accepted      = 1'b0;
        retire_valid  = 1'b0;
        flush         = 1'b1;
        @(posedge clk);
        #2;
        flush = 1'b0;
    endtask

    initial begin
        rst_n         = 1'b0;
        flush         = 1'b0;
        request_valid = 1'b0;
        load          = 1'b0;
        store         = 1'b0;
        addr          = '0;
        be            = 4'b0000;
        fn3           = '0;
        data_in       = 32'h0;
        id            = '0;
        retire_valid  = 1'b0;
        retire_id     = '0;
        accepted      = 1'b0;
        lfsr_state    = 32'h1f37_2894;
        next_id       = '0;
        took          = 1'b0;
        hold_accept   = 1'b0;
        req_kind      = 0;
        req_delay     = 1;
        issue_left    = 0;

        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;

        // Mixed traffic, then both kinds of back-pressure
        issue_and_run(0, NUM_MIXED);
        drain();
        fill_until_stalled(1);
        fill_until_stalled(2);

        // Flush with traffic in flight
        issue_and_run(0, NUM_FLUSH);
        flush_queues();
        issue_and_run(0, NUM_FLUSH);
        drain();

        repeat (4) step_cycle();
        @(negedge clk);
        flag_equals("empty", empty, 1'b1);
        flag_equals("transaction_ready", transaction_ready, 1'b0);
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
logic/lsq_pkg.sv
logic/lsq_addr_hash.sv
logic/lsq_store_queue.sv
logic/lsq_load_queue.sv
logic/lsq_output_select.sv
logic/load_store_queue.sv
testbench/lsq_tb.sv
